//--- verilog/core_mem_cfg.svh
// Memory subsystem configuration macros
// Memory depths, data-address region bounds and control-register offsets
`ifndef CORE_MEM_CFG_SVH
`define CORE_MEM_CFG_SVH

// Memory depths in 32-bit words
`define IMEM_DEPTH 1024
`define DMEM_DEPTH 1024

// Address bits compared against the region bounds
`define REGION_MSB 31
`define REGION_LSB 12

// Region bounds, in units of 4 KB
`define IMEM_FLOOR 20'h0
`define IMEM_ROOF 20'h0
`define DMEM_FLOOR 20'h1
`define DMEM_ROOF 20'h1
`define CR_FLOOR 20'hC
`define CR_ROOF 20'hC

// Control-register byte offsets inside the CR region
`define CR_LED 8'h00
`define CR_SEG 8'h04
`define CR_SCRATCH 8'h08
`define CR_BUTTON0 8'h10
`define CR_BUTTON1 8'h14
`define CR_SWITCH 8'h18

`endif

//--- verilog/core_mem_pkg.sv
// Memory-bus types shared by the core-facing side
// Data and instruction words, byte enables, request struct, region enum
package core_mem_pkg;

    // Data word as seen on the load/store path
    typedef logic [31:0] tWord;

    // Instruction word returned to fetch
    typedef logic [31:0] tInstr;

    // One enable per byte lane of a word
    typedef logic [3:0] tByteEn;

    //----------------------------------------------------------------------
    // One data access from the memory stage
    //----------------------------------------------------------------------
    // Write data and byte enables arrive unshifted
    // wrEn and rdEn are single-cycle strobes, never both high
    typedef struct packed {
        logic [31:0] addr;
        tWord        wrData;
        tByteEn      byteEn;
        logic        wrEn;
        logic        rdEn;
    } tMemReq;

    //----------------------------------------------------------------------
    // Data-address regions
    //----------------------------------------------------------------------
    // REG_NONE covers every address outside the mapped windows
    typedef enum logic [1:0] {
        REG_NONE,
        REG_IMEM,
        REG_DMEM,
        REG_CR
    } tRegion;

endpackage

//--- verilog/fpga_io_pkg.sv
// Board I/O types
// Raw inputs from buttons and switches, outputs to LEDs and digits
package fpga_io_pkg;

    // Board inputs, asynchronous to Clk
    typedef struct packed {
        logic       button0;
        logic       button1;
        // Slide switches
        logic [9:0] sw;
    } tFpgaIn;

    // Board outputs, driven straight from registers
    typedef struct packed {
        // One bit per LED
        logic [9:0]  led;
        // Six 4-bit digits, digit 0 in the low nibble
        logic [23:0] seg;
    } tFpgaOut;

endpackage

//--- verilog/sync_ram.sv
// Synchronous single-clock RAM
// One registered read port, one byte-enabled write port
// Word type set by parameter so one block serves instructions and data
`timescale 1ns/1ps
`include "core_mem_cfg.svh"

module sync_ram #(
    parameter int  DEPTH = `DMEM_DEPTH,
    parameter type wordT = logic [31:0]
) (
    input  logic                     Clk,
    // Read port
    input  logic [$clog2(DEPTH)-1:0] rdIdx,
    input  logic                     rdEn,
    output wordT                     rdData,
    // Write port
    input  logic [$clog2(DEPTH)-1:0] wrIdx,
    input  wordT                     wrData,
    input  logic [3:0]               byteEn,
    input  logic                     wrEn
);

    // Byte lanes in one word
    localparam int LANES = $bits(wordT) / 8;

    // Storage array, contents undefined after power-up
    wordT mem [DEPTH];

    //----------------------------------------------------------------------
    // Write port
    //----------------------------------------------------------------------
    // Only lanes with their enable set are touched
    always_ff @(posedge Clk) begin
        if (wrEn) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (byteEn[lane]) begin
                    mem[wrIdx][8*lane +: 8] <= wrData[8*lane +: 8];
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // Read port
    //----------------------------------------------------------------------
    // Data valid the cycle after rdEn
    // Output holds its last value while rdEn is low
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdData <= mem[rdIdx];
        end
    end

endmodule

//--- verilog/cr_mem.sv
// Control-register block mapped into the data address space
// Input synchronizers for buttons and switches
// LED, seven-segment and scratch registers with board outputs
// Registered read response
`timescale 1ns/1ps
`include "core_mem_cfg.svh"

module cr_mem (
    input  logic                  Clk,
    input  logic                  rstN,
    // Access from the wrapper, already qualified by the CR region
    input  logic [31:0]           addr,
    input  core_mem_pkg::tWord    wrData,
    input  logic                  wrEn,
    input  logic                  rdEn,
    output core_mem_pkg::tWord    rdData,
    // Board side
    input  fpga_io_pkg::tFpgaIn   fpgaIn,
    output fpga_io_pkg::tFpgaOut  fpgaOut
);

    import core_mem_pkg::*;
    import fpga_io_pkg::*;

    // Synchronizer stages
    tFpgaIn  syncMeta;
    tFpgaIn  syncQ;

    // Writable registers
    tFpgaOut outQ;
    tWord    scratchQ;

    // Read data before the response register
    tWord    rdNext;

    //----------------------------------------------------------------------
    // Input synchronizers
    //----------------------------------------------------------------------
    // Two flops per bit, inputs are asynchronous to Clk
    // A read sees an input held for three cycles
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            syncMeta <= '0;
            syncQ    <= '0;
        end else begin
            syncMeta <= fpgaIn;
            syncQ    <= syncMeta;
        end
    end

    //----------------------------------------------------------------------
    // Register writes
    //----------------------------------------------------------------------
    // Full word written, byte enables play no part here
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            outQ     <= '0;
            scratchQ <= '0;
        end else if (wrEn) begin
            case (addr[7:0])
                `CR_LED:     outQ.led <= wrData[9:0];
                `CR_SEG:     outQ.seg <= wrData[23:0];
                `CR_SCRATCH: scratchQ <= wrData;
                // Buttons, switches and unmapped offsets drop the write
                default:     ;
            endcase
        end
    end

    // LEDs and digits follow the registers directly
    assign fpgaOut = outQ;

    //----------------------------------------------------------------------
    // Read decode
    //----------------------------------------------------------------------
    always_comb begin
        case (addr[7:0])
            `CR_LED:     rdNext = tWord'(outQ.led);
            `CR_SEG:     rdNext = tWord'(outQ.seg);
            `CR_SCRATCH: rdNext = scratchQ;
            `CR_BUTTON0: rdNext = tWord'(syncQ.button0);
            `CR_BUTTON1: rdNext = tWord'(syncQ.button1);
            `CR_SWITCH:  rdNext = tWord'(syncQ.sw);
            // Unmapped offset
            default:     rdNext = '0;
        endcase
    end

    // Response register, updated only by a read
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= rdNext;
        end
    end

endmodule

//--- verilog/core_mem_wrap.sv
// Memory subsystem top level
// Region decode of the data address and steering to the three blocks
// Store alignment of data and byte enables
// Load alignment and response mux one cycle after the request
// Instances of instruction memory, data memory and control registers
`timescale 1ns/1ps
`include "core_mem_cfg.svh"

module core_mem_wrap (
    input  logic                  Clk,
    input  logic                  rstN,
    // Fetch port
    input  logic [31:0]           pc,
    input  logic                  fetchEn,
    output core_mem_pkg::tInstr   instr,
    // Data port
    input  core_mem_pkg::tMemReq  memReq,
    output core_mem_pkg::tWord    rdRsp,
    // Board I/O
    input  fpga_io_pkg::tFpgaIn   fpgaIn,
    output fpga_io_pkg::tFpgaOut  fpgaOut
);

    import core_mem_pkg::*;

    // Word-index widths of the two RAMs
    localparam int IMEM_AW  = $clog2(`IMEM_DEPTH);
    localparam int DMEM_AW  = $clog2(`DMEM_DEPTH);
    localparam int REGION_W = `REGION_MSB - `REGION_LSB + 1;

    // What the response cycle needs to know about its request
    typedef struct packed {
        tRegion     region;
        logic [1:0] byteOff;
    } tRspCtl;

    //----------------------------------------------------------------------
    // Region decode
    //----------------------------------------------------------------------
    // Matches when the region bits fall inside FLOOR..ROOF
    function automatic tRegion decodeRegion(input logic [31:0] addr);
        logic [REGION_W-1:0] regionBits;
        regionBits = addr[`REGION_MSB:`REGION_LSB];
        if (regionBits >= `IMEM_FLOOR && regionBits <= `IMEM_ROOF) begin
            return REG_IMEM;
        end
        if (regionBits >= `DMEM_FLOOR && regionBits <= `DMEM_ROOF) begin
            return REG_DMEM;
        end
        if (regionBits >= `CR_FLOOR && regionBits <= `CR_ROOF) begin
            return REG_CR;
        end
        return REG_NONE;
    endfunction

    tRegion reqRegion;
    tWord   alignWrData;
    tByteEn alignByteEn;
    logic   imemWrEn;
    logic   dmemWrEn;
    logic   dmemRdEn;
    logic   crWrEn;
    logic   crRdEn;
    tRspCtl rspCtlQ;
    tWord   dmemRdData;
    tWord   crRdData;

    assign reqRegion = decodeRegion(memReq.addr);

    // Strobes qualified per region
    // IMEM region takes stores from the loader, data reads there give zero
    assign imemWrEn = memReq.wrEn && (reqRegion == REG_IMEM);
    assign dmemWrEn = memReq.wrEn && (reqRegion == REG_DMEM);
    assign dmemRdEn = memReq.rdEn && (reqRegion == REG_DMEM);
    assign crWrEn   = memReq.wrEn && (reqRegion == REG_CR);
    assign crRdEn   = memReq.rdEn && (reqRegion == REG_CR);

    //----------------------------------------------------------------------
    // Store alignment
    //----------------------------------------------------------------------
    // Byte offset moves data and lanes up, overflow bits are dropped
    assign alignWrData = memReq.wrData << {memReq.addr[1:0], 3'b000};
    assign alignByteEn = memReq.byteEn << memReq.addr[1:0];

    //----------------------------------------------------------------------
    // Response stage
    //----------------------------------------------------------------------
    // Captured only on a read so rdRsp holds between reads
    // Reset value selects zero until the first read
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rspCtlQ.region  <= REG_NONE;
            rspCtlQ.byteOff <= 2'b00;
        end else if (memReq.rdEn) begin
            rspCtlQ.region  <= reqRegion;
            rspCtlQ.byteOff <= memReq.addr[1:0];
        end
    end

    // DMEM loads shifted down and zero-filled
    // IMEM and unmapped regions answer zero
    always_comb begin
        case (rspCtlQ.region)
            REG_DMEM: rdRsp = dmemRdData >> {rspCtlQ.byteOff, 3'b000};
            REG_CR:   rdRsp = crRdData;
            default:  rdRsp = '0;
        endcase
    end

    //----------------------------------------------------------------------
    // Instruction memory
    //----------------------------------------------------------------------
    // Read by fetch, written through the data port
    sync_ram #(
        .DEPTH (`IMEM_DEPTH),
        .wordT (tInstr)
    ) uImem (
        .Clk    (Clk),
        .rdIdx  (pc[IMEM_AW+1:2]),
        .rdEn   (fetchEn),
        .rdData (instr),
        .wrIdx  (memReq.addr[IMEM_AW+1:2]),
        .wrData (alignWrData),
        .byteEn (alignByteEn),
        .wrEn   (imemWrEn)
    );

    //----------------------------------------------------------------------
    // Data memory
    //----------------------------------------------------------------------
    sync_ram #(
        .DEPTH (`DMEM_DEPTH),
        .wordT (tWord)
    ) uDmem (
        .Clk    (Clk),
        .rdIdx  (memReq.addr[DMEM_AW+1:2]),
        .rdEn   (dmemRdEn),
        .rdData (dmemRdData),
        .wrIdx  (memReq.addr[DMEM_AW+1:2]),
        .wrData (alignWrData),
        .byteEn (alignByteEn),
        .wrEn   (dmemWrEn)
    );

    //----------------------------------------------------------------------
    // Control registers
    //----------------------------------------------------------------------
    // Sees the unshifted request, full-word accesses only
    cr_mem uCrMem (
        .Clk     (Clk),
        .rstN    (rstN),
        .addr    (memReq.addr),
        .wrData  (memReq.wrData),
        .wrEn    (crWrEn),
        .rdEn    (crRdEn),
        .rdData  (crRdData),
        .fpgaIn  (fpgaIn),
        .fpgaOut (fpgaOut)
    );

endmodule

//--- tests/clk_gen.sv
// Testbench clock and power-on reset
// 20 ns clock, reset held low for four rising edges
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #(PERIOD / 2) Clk = ~Clk;
    end

    // Starts high so the DUT sees a real falling edge of reset
    initial begin
        rstN <= 1'b1;
        #1;
        rstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

//--- tests/core_mem_chk.sv
// Concurrent assertions on the memory subsystem top level
// Unmapped reads, outputs in reset, exclusive strobes
`timescale 1ns/1ps
`include "core_mem_cfg.svh"

module core_mem_chk (
    input logic                 Clk,
    input logic                 rstN,
    input core_mem_pkg::tMemReq memReq,
    input core_mem_pkg::tWord   rdRsp,
    input fpga_io_pkg::tFpgaOut fpgaOut
);

    logic [`REGION_MSB-`REGION_LSB:0] regionBits;
    logic                             mapped;

    // Address hits one of the three windows
    assign regionBits = memReq.addr[`REGION_MSB:`REGION_LSB];
    assign mapped = regionBits inside {[`IMEM_FLOOR:`IMEM_ROOF],
                                       [`DMEM_FLOOR:`DMEM_ROOF],
                                       [`CR_FLOOR:`CR_ROOF]};

    // Unmapped data read answers zero one cycle later
    noneReadZero: assert property (@(posedge Clk) disable iff (!rstN)
        (memReq.rdEn && !mapped) |=> (rdRsp == '0))
        else $error("Read outside the mapped regions returned nonzero data");

    // Board outputs cleared during reset
    resetOutputsZero: assert property (@(posedge Clk) !rstN |-> (fpgaOut == '0))
        else $error("fpgaOut not zero while reset is asserted");

    oneStrobe: assert property (@(posedge Clk) disable iff (!rstN)
        !(memReq.wrEn && memReq.rdEn))
        else $error("wrEn and rdEn high in the same cycle");

endmodule

bind core_mem_wrap core_mem_chk uChk (
    .Clk     (Clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .rdRsp   (rdRsp),
    .fpgaOut (fpgaOut)
);

//--- tests/core_mem_tb.sv
// Testbench for the memory subsystem
// Reference models, bus driver tasks, compare tasks, directed tests
`timescale 1ns/1ps
`include "core_mem_cfg.svh"

module core_mem_tb;

    import core_mem_pkg::*;
    import fpga_io_pkg::*;

    localparam logic [31:0] DMEM_BASE = {`DMEM_FLOOR, 12'h000};
    localparam logic [31:0] CR_BASE   = {`CR_FLOOR, 12'h000};
    localparam int RESET_TIMEOUT = 50;

    logic        Clk;
    logic        porRstN;
    logic        softRstN;
    logic        rstN;
    logic [31:0] pc;
    logic        fetchEn;
    tInstr       instr;
    tMemReq      memReq;
    tWord        rdRsp;
    tFpgaIn      fpgaIn;
    tFpgaOut     fpgaOut;

    // Reference models
    tInstr imemModel [`IMEM_DEPTH];
    tWord  dmemModel [`DMEM_DEPTH];
    // CR read values, indexed by offset bits 4:2
    tWord  crModel [8];

    int seed = 9302;
    int checkCount = 0;
    int errorCount = 0;
    int timeoutCount = 0;

    clk_gen uClkGen (.Clk(Clk), .rstN(porRstN));

    // Power-on reset combined with the mid-test reset
    assign rstN = porRstN & softRstN;

    core_mem_wrap u_dut (
        .Clk(Clk), .rstN(rstN), .pc(pc), .fetchEn(fetchEn), .instr(instr),
        .memReq(memReq), .rdRsp(rdRsp), .fpgaIn(fpgaIn), .fpgaOut(fpgaOut)
    );

    //--------------------------------------------------------------------
    // Compare tasks
    //--------------------------------------------------------------------
    task automatic checkWord(input tWord actual, input tWord expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkInstr(input tInstr actual, input tInstr expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t ns: %s gave %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkFpgaOut(input tFpgaOut actual, input tFpgaOut expected,
                                input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t ns: %s led %h seg %h, expected led %h seg %h", $time,
                     what, actual.led, actual.seg, expected.led, expected.seg);
        end
    endtask

    //--------------------------------------------------------------------
    // Address helpers and models
    //--------------------------------------------------------------------
    function automatic logic [31:0] dmemAddr(input int idx);
        return DMEM_BASE + (32'(idx) << 2);
    endfunction

    function automatic logic [31:0] crAddr(input logic [7:0] off);
        return CR_BASE | {24'h0, off};
    endfunction

    // Store rule: data and lanes move up by the byte offset, overflow lost
    function automatic tWord applyStore(input tWord old, input tWord data, input tByteEn be,
                                        input logic [1:0] off);
        tWord   shData;
        tByteEn shBe;
        tWord   res;
        shData = data << (8 * off);
        shBe = be << off;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (shBe[lane]) res[8*lane +: 8] = shData[8*lane +: 8];
        end
        return res;
    endfunction

    function automatic tFpgaOut expectedOut();
        tFpgaOut exp;
        exp.led = crModel[0][9:0];
        exp.seg = crModel[1][23:0];
        return exp;
    endfunction

    //--------------------------------------------------------------------
    // Bus drivers
    //--------------------------------------------------------------------
    task automatic driveReq(input logic [31:0] addr, input tWord data, input tByteEn be,
                            input logic wr, input logic rd);
        tMemReq req;
        req.addr = addr;
        req.wrData = data;
        req.byteEn = be;
        req.wrEn = wr;
        req.rdEn = rd;
        @(posedge Clk);
        memReq <= req;
    endtask

    task automatic idleCycle();
        driveReq('0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) @(posedge Clk);
    endtask

    // Response sampled at the falling edge after the capturing edge
    task automatic readCheck(input logic [31:0] addr, input tWord expected, input string what);
        driveReq(addr, '0, '0, 1'b0, 1'b1);
        idleCycle();
        @(negedge Clk);
        checkWord(rdRsp, expected, what);
    endtask

    task automatic crWrite(input logic [7:0] off, input tWord data);
        // Random byte enables, the CR block takes the full word
        driveReq(crAddr(off), data, 4'($random(seed)), 1'b1, 1'b0);
        case (off)
            `CR_LED:     crModel[0] = {22'h0, data[9:0]};
            `CR_SEG:     crModel[1] = {8'h0, data[23:0]};
            `CR_SCRATCH: crModel[2] = data;
            default:     ;
        endcase
    endtask

    // Input held from this edge; a read issued after the next edge sees it
    task automatic setInputs(input tFpgaIn value);
        @(posedge Clk);
        fpgaIn <= value;
        crModel[4] = {31'h0, value.button0};
        crModel[5] = {31'h0, value.button1};
        crModel[6] = {22'h0, value.sw};
        @(posedge Clk);
    endtask

    task automatic readAllCr(input string what);
        logic [7:0] offs [6];
        // Switch read lands three cycles after the inputs change
        offs = '{`CR_SWITCH, `CR_BUTTON0, `CR_BUTTON1, `CR_LED, `CR_SEG, `CR_SCRATCH};
        for (int i = 0; i < 6; i++) begin
            readCheck(crAddr(offs[i]), crModel[offs[i][4:2]], what);
        end
    endtask

    task automatic waitResetRelease(input string phase);
        int cycles;
        cycles = 0;
        @(posedge Clk);
        while (rstN !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge Clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutCount++;
            $display("Timeout: reset was never released during the %s", phase);
        end
    endtask

    //--------------------------------------------------------------------
    // Directed tests
    //--------------------------------------------------------------------
    task automatic testInstrFetch();
        int    idx [8];
        tInstr data;
        // Loader stores through the data port
        for (int i = 0; i < 8; i++) begin
            idx[i] = int'($unsigned($random(seed)) % `IMEM_DEPTH);
            data = tInstr'($random(seed));
            imemModel[idx[i]] = data;
            driveReq(32'(idx[i]) << 2, data, 4'hF, 1'b1, 1'b0);
        end
        idleCycle();
        for (int i = 0; i < 8; i++) begin
            @(posedge Clk);
            pc <= 32'(idx[i]) << 2;
            fetchEn <= 1'b1;
            @(posedge Clk);
            fetchEn <= 1'b0;
            @(negedge Clk);
            checkInstr(instr, imemModel[idx[i]], "fetch");
        end
        readCheck(32'(idx[0]) << 2, '0, "IMEM-region data read");
        // instr holds while fetchEn stays low
        checkInstr(instr, imemModel[idx[7]], "held fetch");
    endtask

    task automatic testWordAccess();
        int   idx [16];
        tWord data;
        for (int i = 0; i < 16; i++) begin
            idx[i] = int'($unsigned($random(seed)) % `DMEM_DEPTH);
            data = tWord'($random(seed));
            dmemModel[idx[i]] = data;
            driveReq(dmemAddr(idx[i]), data, 4'hF, 1'b1, 1'b0);
        end
        // Pipelined reads, each response one cycle behind its request
        for (int i = 0; i <= 16; i++) begin
            if (i < 16) driveReq(dmemAddr(idx[i]), '0, '0, 1'b0, 1'b1);
            else idleCycle();
            @(negedge Clk);
            if (i > 0) checkWord(rdRsp, dmemModel[idx[i-1]], "DMEM word read");
        end
    endtask

    task automatic testSubWord();
        int     idx;
        tWord   data;
        tByteEn be;
        idx = int'($unsigned($random(seed)) % `DMEM_DEPTH);
        data = tWord'($random(seed));
        dmemModel[idx] = data;
        driveReq(dmemAddr(idx), data, 4'hF, 1'b1, 1'b0);
        // Bytes then halfwords at offsets 1 to 3
        for (int size = 0; size < 2; size++) begin
            for (int off = 1; off < 4; off++) begin
                data = tWord'($random(seed));
                be = (size == 0) ? 4'b0001 : 4'b0011;
                dmemModel[idx] = applyStore(dmemModel[idx], data, be, 2'(off));
                driveReq(dmemAddr(idx) + 32'(off), data, be, 1'b1, 1'b0);
                readCheck(dmemAddr(idx), dmemModel[idx], "sub-word store");
            end
        end
    endtask

    task automatic testUnalignedLoad();
        int   idx;
        tWord data;
        for (int w = 0; w < 4; w++) begin
            idx = int'($unsigned($random(seed)) % `DMEM_DEPTH);
            data = tWord'($random(seed));
            dmemModel[idx] = data;
            driveReq(dmemAddr(idx), data, 4'hF, 1'b1, 1'b0);
            for (int off = 0; off < 4; off++) begin
                readCheck(dmemAddr(idx) + 32'(off), dmemModel[idx] >> (8 * off),
                          "unaligned load");
            end
        end
    endtask

    task automatic testControlRegs();
        tFpgaIn      ins;
        logic [31:0] noneAddrs [3];
        noneAddrs = '{32'h0000_2000, 32'h0000_D000, 32'hFFFF_0000};
        // LED and SEG reach the board one edge after the write
        crWrite(`CR_LED, tWord'($random(seed)));
        idleCycle();
        @(negedge Clk);
        checkFpgaOut(fpgaOut, expectedOut(), "LED write");
        crWrite(`CR_SEG, tWord'($random(seed)));
        idleCycle();
        @(negedge Clk);
        checkFpgaOut(fpgaOut, expectedOut(), "SEG write");
        crWrite(`CR_SCRATCH, tWord'($random(seed)));
        idleCycle();
        for (int n = 0; n < 2; n++) begin
            ins = 12'($random(seed));
            setInputs(ins);
            readAllCr("CR readback");
            // Read-only and unmapped offsets drop stores
            crWrite(`CR_BUTTON0, tWord'($random(seed)));
            crWrite(`CR_SWITCH, tWord'($random(seed)));
            crWrite(8'h0C, tWord'($random(seed)));
            readAllCr("CR after read-only store");
            checkFpgaOut(fpgaOut, expectedOut(), "fpgaOut after read-only store");
        end
        readCheck(crAddr(8'h0C), '0, "unmapped CR offset");
        readCheck(crAddr(8'hFC), '0, "unmapped CR offset");
        // Scratch read first so a stale nonzero response would show
        for (int i = 0; i < 3; i++) begin
            readCheck(crAddr(`CR_SCRATCH), crModel[2], "scratch");
            readCheck(noneAddrs[i], '0, "NONE-region read");
        end
    endtask

    task automatic testMidReset();
        int   idx;
        tWord data;
        // Nonzero DMEM response left on rdRsp going into reset
        idx = int'($unsigned($random(seed)) % `DMEM_DEPTH);
        data = tWord'($random(seed)) | 32'h1;
        dmemModel[idx] = data;
        driveReq(dmemAddr(idx), data, 4'hF, 1'b1, 1'b0);
        readCheck(dmemAddr(idx), dmemModel[idx], "DMEM read before reset");
        setInputs('0);
        @(posedge Clk);
        softRstN <= 1'b0;
        waitCycles(2);
        @(negedge Clk);
        checkFpgaOut(fpgaOut, '0, "fpgaOut in reset");
        @(posedge Clk);
        softRstN <= 1'b1;
        waitResetRelease("mid-test reset");
        crModel[0] = '0;
        crModel[1] = '0;
        crModel[2] = '0;
        @(negedge Clk);
        checkFpgaOut(fpgaOut, '0, "fpgaOut after reset");
        checkWord(rdRsp, '0, "rdRsp after reset");
        readAllCr("CR after reset");
    endtask

    //--------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------
    initial begin
        pc <= '0;
        fetchEn <= 1'b0;
        memReq <= '0;
        fpgaIn <= '0;
        softRstN <= 1'b1;
        for (int i = 0; i < 8; i++) crModel[i] = '0;
        waitResetRelease("power-on reset");
        if (timeoutCount == 0) begin
            testInstrFetch();
            testWordAccess();
            testSubWord();
            testUnalignedLoad();
            testControlRegs();
            testMidReset();
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+verilog
verilog/core_mem_pkg.sv
verilog/fpga_io_pkg.sv
verilog/sync_ram.sv
verilog/cr_mem.sv
verilog/core_mem_wrap.sv
tests/clk_gen.sv
tests/core_mem_chk.sv
tests/core_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
# The run passes only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module core_mem_tb -f all.f \
    --Mdir obj_dir -o core_mem_sim \
    && ./obj_dir/core_mem_sim | tee sim.log \
    && grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
